/* flist.f */
hdl/ni_pkg.sv
hdl/flit_counter.sv
hdl/vc_rd_buffer.sv
hdl/pkt_rx_fsm.sv
hdl/ni_csr.sv
hdl/ni_rx_top.sv
verif/ni_rx_chk.sv
verif/ni_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the NI receive testbench with Verilator.
set -u

ROOT="$(cd "$(dirname "${BASH_SOURCE[0]}")" && pwd)"
cd "$ROOT" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module ni_rx_tb -Mdir "$OBJ_DIR"; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vni_rx_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "Result: failed"
  exit 1
fi

echo "Result: passed"
exit 0

/* verif/ni_rx_tb.sv */
/*
 * Testbench for the NI receive top level.
 * CSR access, packet reception, interrupt modes and back-pressure.
 */
`timescale 1ns/100ps
`default_nettype none

module ni_rx_tb;

  import ni_pkg::*;

  localparam int unsigned FifoDepth     = 4;
  localparam int unsigned NumPkts       = 40;
  localparam int unsigned TimeoutCycles = 400 + 40 * NumPkts; // Fixed tests plus per packet.

  logic                  clk_axi = 1'b0;
  logic                  arst_axi;
  flit_t                 flit;
  csr_req_t              csr_req;
  csr_resp_t             csr_resp;
  logic                  rd_pop;
  vc_id_t                rd_vc;
  flit_data_t            rd_data;
  irq_t                  irq;
  logic [NumVirtChn-1:0] rx_ready;
  logic                  tx_full;

  flit_data_t  model_q [NumVirtChn][$];          // Expected buffer contents.
  logic [31:0] lfsr_q    = 32'd91807;
  int unsigned err_cnt   = 0;
  int unsigned err_mark  = 0;
  int unsigned check_cnt = 0;
  int unsigned test_cnt  = 0;

  ni_rx_top #(
    .ROUTER_X_ID (4'd2),
    .ROUTER_Y_ID (4'd3),
    .FIFO_DEPTH  (FifoDepth)
  ) DUT (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .flit_i     (flit),
    .rx_ready_o (rx_ready),
    .csr_req_i  (csr_req),
    .csr_resp_o (csr_resp),
    .rd_pop_i   (rd_pop),
    .rd_vc_i    (rd_vc),
    .rd_data_o  (rd_data),
    .irq_o      (irq),
    .tx_full_i  (tx_full)
  );

  always #10 clk_axi = ~clk_axi;                 // 20 ns period.

  // Fibonacci LFSR, taps 32/22/2/1, one step per bit.
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("Test %0d %s done, %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // ******************************************************************
  // CSR access, two cycles per request.
  // ******************************************************************
  task automatic csr_access(input logic wr, input csr_addr_t off, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_axi);
    csr_req <= '{valid: 1'b1, write: wr, addr: CsrBaseAddr + off, wdata: wdata};
    @(negedge clk_axi);
    err = csr_resp.error;                        // Write error, same cycle.
    @(posedge clk_axi);
    csr_req <= '0;
    @(negedge clk_axi);
    rdata = csr_resp.rdata;
    if (!wr) begin
      err = csr_resp.error;                      // Read error, one cycle on.
    end
  endtask

  task automatic read_expect(input string name, input csr_addr_t off, input logic [31:0] exp);
    logic [31:0] d;
    logic        e;
    csr_access(1'b0, off, '0, d, e);
    expect_eq({"csr_resp_o.rdata ", name}, d, exp);
    expect_eq({"csr_resp_o.error ", name}, 32'(e), 32'd0);
  endtask

  task automatic write_expect(input string name, input csr_addr_t off,
                              input logic [31:0] wdata, input logic exp_err);
    logic [31:0] d;
    logic        e;
    csr_access(1'b1, off, wdata, d, e);
    expect_eq({"csr_resp_o.error ", name}, 32'(e), 32'(exp_err));
  endtask

  // ******************************************************************
  // Flit and pop stimulus.
  // ******************************************************************
  task automatic send_pkt(input vc_id_t vc, input pkt_size_t len);
    flit_t f;
    logic  taken;
    taken = (model_q[vc].size() < FifoDepth);   // Head needs room.
    for (int unsigned k = 0; k < 32'(len); k++) begin
      f.valid = 1'b1;
      f.head  = (k == 0);
      f.vc    = vc;
      if (k == 0) begin
        f.data = (rand_bits(24) << 8) | 32'(len); // Length in low byte.
      end else begin
        f.data = rand_bits(32);
      end
      if (taken) begin
        model_q[vc].push_back(f.data);
      end
      @(posedge clk_axi);
      flit <= f;
    end
    @(posedge clk_axi);
    flit <= '0;
    @(negedge clk_axi);
  endtask

  task automatic pop_expect(input vc_id_t vc);
    flit_data_t exp;
    exp = model_q[vc].pop_front();
    @(posedge clk_axi);
    rd_vc  <= vc;
    rd_pop <= 1'b1;
    @(negedge clk_axi);
    expect_eq("rd_data_o", rd_data, exp);
    @(posedge clk_axi);
    rd_pop <= 1'b0;
    @(negedge clk_axi);
  endtask

  task automatic drain_vc(input vc_id_t vc);
    while (model_q[vc].size() > 0) begin
      pop_expect(vc);
    end
  endtask

  task automatic drain_all();
    for (int i = 0; i < NumVirtChn; i++) begin
      drain_vc(vc_id_t'(i));
    end
  endtask

  // Lines, summary bit and status register against one expected vector.
  task automatic irq_expect(input logic [NumVirtChn-1:0] exp);
    expect_eq("irq_o.vcs", 32'(irq.vcs), 32'(exp));
    expect_eq("irq_o.trig", 32'(irq.trig), 32'(|exp));
    read_expect("IrqStatus", IrqStatus, 32'(exp));
  endtask

  // ******************************************************************
  // Test sequence.
  // ******************************************************************
  initial begin
    vc_id_t      vc;
    pkt_size_t   len;
    logic [31:0] rdata;
    logic        err;
    arst_axi <= 1'b1;
    flit     <= '0;
    csr_req  <= '0;
    rd_pop   <= 1'b0;
    rd_vc    <= '0;
    tx_full  <= 1'b0;
    repeat (4) @(posedge clk_axi);
    arst_axi <= 1'b0;

    @(negedge clk_axi);
    expect_eq("irq_o", 32'(irq), 32'd0);
    read_expect("NiVersion", NiVersion, NiVersionLabel);
    read_expect("RouterX", RouterX, 32'd2);
    read_expect("RouterY", RouterY, 32'd3);
    read_expect("IrqMask", IrqMask, 32'hFFFF_FFFF);
    read_expect("IrqMux", IrqMux, 32'(IRQ_DEFAULT));
    finish_test("reset values");

    write_expect("IrqMux", IrqMux, 32'(IRQ_COMP), 1'b0);
    read_expect("IrqMux", IrqMux, 32'(IRQ_COMP));
    write_expect("IrqMask", IrqMask, 32'h0000_A5C3, 1'b0);
    read_expect("IrqMask", IrqMask, 32'h0000_A5C3);
    write_expect("NiVersion", NiVersion, 32'h1, 1'b1);
    write_expect("IrqStatus", IrqStatus, 32'h1, 1'b1);
    csr_access(1'b0, 16'h002C, '0, rdata, err); // One past the last VC.
    expect_eq("csr_resp_o.error unmapped", 32'(err), 32'd1);
    @(posedge clk_axi);
    tx_full <= 1'b1;
    read_expect("TxFull", TxFull, 32'd1);
    @(posedge clk_axi);
    tx_full <= 1'b0;
    read_expect("TxFull", TxFull, 32'd0);
    write_expect("IrqMux", IrqMux, 32'(IRQ_DEFAULT), 1'b0);
    write_expect("IrqMask", IrqMask, 32'hFFFF_FFFF, 1'b0);
    finish_test("register access");

    for (int unsigned p = 0; p < NumPkts; p++) begin
      vc  = vc_id_t'(rand_bits(2) % 3);
      len = pkt_size_t'(rand_bits(2)) + 8'd1;
      if (model_q[vc].size() + int'(len) > FifoDepth) begin
        drain_vc(vc);                            // Keep the packet whole.
      end
      send_pkt(vc, len);
      read_expect("PktSize", PktSizeBase + csr_addr_t'(4 * vc), 32'(len));
    end
    drain_all();
    finish_test("packet reception");

    send_pkt(2'd0, 8'd1);
    irq_expect(3'b001);
    drain_all();
    irq_expect(3'b000);
    write_expect("IrqMux", IrqMux, 32'(IRQ_EMPTY), 1'b0);
    write_expect("IrqMask", IrqMask, 32'h5, 1'b0);
    send_pkt(2'd0, 8'd1);
    send_pkt(2'd1, 8'd1);
    irq_expect(3'b001);                          // Channel 1 masked.
    drain_all();
    write_expect("IrqMux", IrqMux, 32'(IRQ_FULL), 1'b0);
    write_expect("IrqMask", IrqMask, 32'h7, 1'b0);
    repeat (FifoDepth - 1) send_pkt(2'd2, 8'd1);
    irq_expect(3'b000);
    send_pkt(2'd2, 8'd1);
    irq_expect(3'b100);
    drain_all();
    write_expect("IrqMux", IrqMux, 32'(IRQ_COMP), 1'b0);
    write_expect("IrqMask", IrqMask, 32'h2, 1'b0);
    send_pkt(2'd1, 8'd1);
    irq_expect(3'b000);
    send_pkt(2'd1, 8'd1);
    irq_expect(3'b010);                          // Occupancy reached 2.
    drain_all();
    write_expect("IrqMux", IrqMux, 32'(IRQ_DEFAULT), 1'b0);
    write_expect("IrqMask", IrqMask, 32'hFFFF_FFFF, 1'b0);
    finish_test("interrupt modes");

    send_pkt(2'd0, 8'(FifoDepth));
    expect_eq("rx_ready_o", 32'(rx_ready), 32'b110);
    send_pkt(2'd0, 8'd2);                        // Head dropped, body discarded.
    read_expect("PktSize0", PktSizeBase, 32'(FifoDepth));
    pop_expect(2'd0);
    expect_eq("rx_ready_o", 32'(rx_ready), 32'b111);
    drain_all();
    send_pkt(2'd0, 8'd2);
    read_expect("PktSize0", PktSizeBase, 32'd2);
    drain_all();
    finish_test("back-pressure");

    if (DUT.u_chk.fail_seen) begin
      $display("The bound checker saw a failing assertion");
      err_cnt++;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (TimeoutCycles) @(posedge clk_axi);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/ni_rx_chk.sv */
/*
 * Assertion checker for the NI receive top level.
 * Bound into ni_rx_top, watches irq, CSR errors and rx_ready.
 */
`timescale 1ns/100ps
`default_nettype none

module ni_rx_chk #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input wire                                          clk_axi,
  input wire                                          arst_axi,
  input ni_pkg::irq_t                                 irq_i,
  input ni_pkg::csr_req_t                             csr_req_i,
  input ni_pkg::csr_resp_t                            csr_resp_i,
  input wire [ni_pkg::NumVirtChn-1:0]                 rx_ready_i,
  input ni_pkg::vc_stat_t [ni_pkg::NumVirtChn-1:0]    vc_stat_i
);

  import ni_pkg::*;

  logic                  ro_write;
  logic [NumVirtChn-1:0] at_depth;               // Channel holds FIFO_DEPTH.
  logic                  fail_trig = 1'b0;
  logic                  fail_ro   = 1'b0;
  logic                  fail_rdy  = 1'b0;
  logic                  fail_rst  = 1'b0;
  logic                  fail_seen;              // Any assertion fired.

  assign fail_seen = fail_trig | fail_ro | fail_rdy | fail_rst;

  // Writes aimed at a read-only register.
  assign ro_write = csr_req_i.valid && csr_req_i.write &&
                    (csr_req_i.addr == CsrBaseAddr + NiVersion ||
                     csr_req_i.addr == CsrBaseAddr + RouterX   ||
                     csr_req_i.addr == CsrBaseAddr + RouterY   ||
                     csr_req_i.addr == CsrBaseAddr + IrqStatus ||
                     csr_req_i.addr == CsrBaseAddr + TxFull);

  always_comb begin
    for (int i = 0; i < NumVirtChn; i++) begin
      at_depth[i] = (vc_stat_i[i].occup >= occup_t'(FIFO_DEPTH));
    end
  end

  // ******************************************************************
  // Properties.
  // ******************************************************************
  a_trig_or: assert property (@(posedge clk_axi) disable iff (arst_axi)
    irq_i.trig == |irq_i.vcs)
    else begin
      $error("irq trig is not the OR of the channel lines");
      fail_trig = 1'b1;
    end

  a_ro_write: assert property (@(posedge clk_axi) disable iff (arst_axi)
    ro_write |-> csr_resp_i.error)
    else begin
      $error("write to a read-only register gave no error");
      fail_ro = 1'b1;
    end

  // Full channel must not advertise room.
  a_ready_full: assert property (@(posedge clk_axi) disable iff (arst_axi)
    (at_depth & rx_ready_i) == '0)
    else begin
      $error("rx_ready high on a channel at full depth");
      fail_rdy = 1'b1;
    end

  a_irq_rst: assert property (@(posedge clk_axi)
    arst_axi |-> (irq_i == '0))
    else begin
      $error("irq active during reset");
      fail_rst = 1'b1;
    end

endmodule

bind ni_rx_top ni_rx_chk #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_chk (
  .clk_axi    (clk_axi),
  .arst_axi   (arst_axi),
  .irq_i      (irq_o),
  .csr_req_i  (csr_req_i),
  .csr_resp_i (csr_resp_o),
  .rx_ready_i (rx_ready_o),
  .vc_stat_i  (vc_stat)
);

`default_nettype wire

/* hdl/ni_rx_top.sv */
/*
 * NoC network interface, receive side.
 * Receive FSM, flit counter, per VC buffers and CSR block.
 */
`timescale 1ns/100ps
`default_nettype none

module ni_rx_top #(
  parameter ni_pkg::coord_t ROUTER_X_ID = '0,
  parameter ni_pkg::coord_t ROUTER_Y_ID = '0,
  parameter int unsigned    FIFO_DEPTH  = 4
) (
  input  wire                             clk_axi,
  input  wire                             arst_axi,
  // Router side.
  input  ni_pkg::flit_t                   flit_i,
  output logic [ni_pkg::NumVirtChn-1:0]   rx_ready_o,
  // Processor side.
  input  ni_pkg::csr_req_t                csr_req_i,
  output ni_pkg::csr_resp_t               csr_resp_o,
  input  wire                             rd_pop_i,
  input  ni_pkg::vc_id_t                  rd_vc_i,
  output ni_pkg::flit_data_t              rd_data_o,
  output ni_pkg::irq_t                    irq_o,
  // Transmit side level.
  input  wire                             tx_full_i
);

  import ni_pkg::*;

  logic       [NumVirtChn-1:0] buf_wr, buf_pop, buf_full;
  flit_data_t                  buf_wdata;
  flit_data_t                  buf_rdata [NumVirtChn];
  vc_stat_t   [NumVirtChn-1:0] vc_stat;
  pkt_size_t  [NumVirtChn-1:0] pkt_size;
  logic                        cnt_load, cnt_dec, cnt_last;
  pkt_size_t                   cnt_val;

  // ******************************************************************
  // Receive path.
  // ******************************************************************
  pkt_rx_fsm u_rx_fsm (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .flit_i     (flit_i),
    .full_i     (buf_full),
    .wr_o       (buf_wr),
    .wdata_o    (buf_wdata),
    .cnt_load_o (cnt_load),
    .cnt_val_o  (cnt_val),
    .cnt_dec_o  (cnt_dec),
    .cnt_last_i (cnt_last),
    .pkt_size_o (pkt_size)
  );

  flit_counter u_flit_cnt (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .load_i     (cnt_load),
    .load_val_i (cnt_val),
    .dec_i      (cnt_dec),
    .last_o     (cnt_last)
  );

  for (genvar i = 0; i < NumVirtChn; i++) begin : g_vc
    assign buf_pop[i]    = rd_pop_i && (rd_vc_i == vc_id_t'(i)); // Pop routing.
    assign buf_full[i]   = vc_stat[i].full;
    assign rx_ready_o[i] = !vc_stat[i].full;

    vc_rd_buffer #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buf (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .wr_i     (buf_wr[i]),
      .wdata_i  (buf_wdata),
      .pop_i    (buf_pop[i]),
      .rdata_o  (buf_rdata[i]),
      .stat_o   (vc_stat[i])
    );
  end

  // Head data of the selected channel; unused ids read zero.
  always_comb begin
    rd_data_o = '0;
    for (int i = 0; i < NumVirtChn; i++) begin
      if (rd_vc_i == vc_id_t'(i)) begin
        rd_data_o = buf_rdata[i];
      end
    end
  end

  // ******************************************************************
  // Register block.
  // ******************************************************************
  ni_csr #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) u_csr (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .csr_req_i  (csr_req_i),
    .csr_resp_o (csr_resp_o),
    .vc_stat_i  (vc_stat),
    .pkt_size_i (pkt_size),
    .tx_full_i  (tx_full_i),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

/* hdl/ni_csr.sv */
/*
 * NI control and status registers.
 * Decodes CSR requests and drives the per channel interrupt lines.
 */
`timescale 1ns/100ps
`default_nettype none

module ni_csr #(
  parameter ni_pkg::coord_t ROUTER_X_ID = '0,
  parameter ni_pkg::coord_t ROUTER_Y_ID = '0
) (
  input  wire                                           clk_axi,
  input  wire                                           arst_axi,
  // CSR access.
  input  ni_pkg::csr_req_t                              csr_req_i,
  output ni_pkg::csr_resp_t                             csr_resp_o,
  // Buffer and packet status.
  input  ni_pkg::vc_stat_t  [ni_pkg::NumVirtChn-1:0]    vc_stat_i,
  input  ni_pkg::pkt_size_t [ni_pkg::NumVirtChn-1:0]    pkt_size_i,
  input  wire                                           tx_full_i,
  // Interrupts.
  output ni_pkg::irq_t                                  irq_o
);

  import ni_pkg::*;

  csr_addr_t   offset;                      // Address inside the window.
  logic        rd_req, wr_req;
  logic        error_rd, error_wr;
  logic [31:0] rd_data;
  logic [31:0] rdata_q;
  logic        error_q;
  irq_mode_e   mode_q, mode_d;
  logic [31:0] mask_q, mask_d;

  assign offset = csr_req_i.addr - CsrBaseAddr;
  assign rd_req = csr_req_i.valid && !csr_req_i.write;
  assign wr_req = csr_req_i.valid &&  csr_req_i.write;

  // Write error is flagged in the request cycle, read error a cycle later.
  assign csr_resp_o.rdata = rdata_q;
  assign csr_resp_o.error = error_q || error_wr;

  // ******************************************************************
  // Write decode.
  // ******************************************************************
  always_comb begin
    error_wr = 1'b0;
    mode_d   = mode_q;
    mask_d   = mask_q;
    if (wr_req) begin
      case (offset)
        IrqMux:  mode_d   = irq_mode_e'(csr_req_i.wdata[1:0]);
        IrqMask: mask_d   = csr_req_i.wdata;
        default: error_wr = 1'b1;   // RO or unmapped.
      endcase
    end
  end

  // ******************************************************************
  // Read decode.
  // ******************************************************************
  always_comb begin
    error_rd = 1'b0;
    rd_data  = rdata_q;             // Hold last value.
    if (rd_req) begin
      case (offset)
        NiVersion: rd_data = NiVersionLabel;
        RouterX:   rd_data = 32'(ROUTER_X_ID);
        RouterY:   rd_data = 32'(ROUTER_Y_ID);
        IrqStatus: rd_data = 32'(irq_o.vcs);
        IrqMux:    rd_data = 32'(mode_q);
        IrqMask:   rd_data = mask_q;
        TxFull:    rd_data = 32'(tx_full_i);
        default: begin
          error_rd = 1'b1;          // Cleared on a packet size hit.
          for (int i = 0; i < NumVirtChn; i++) begin
            if (offset == PktSizeBase + csr_addr_t'(4 * i)) begin
              rd_data  = 32'(pkt_size_i[i]);
              error_rd = 1'b0;
            end
          end
        end
      endcase
    end
  end

  // ******************************************************************
  // Interrupt generation, purely combinational.
  // ******************************************************************
  always_comb begin
    irq_o = '0;
    for (int i = 0; i < NumVirtChn; i++) begin
      case (mode_q)
        IRQ_DEFAULT: irq_o.vcs[i] = !vc_stat_i[i].empty;
        IRQ_EMPTY:   irq_o.vcs[i] = !vc_stat_i[i].empty && mask_q[i];
        IRQ_FULL:    irq_o.vcs[i] =  vc_stat_i[i].full  && mask_q[i];
        IRQ_COMP:    irq_o.vcs[i] = (vc_stat_i[i].occup >= occup_t'(mask_q[15:0]));
        default:     irq_o.vcs[i] = !vc_stat_i[i].empty;
      endcase
    end
    irq_o.trig = |irq_o.vcs;        // Summary line.
  end

  // Response and config registers.
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      rdata_q <= '0;
      error_q <= 1'b0;
      mode_q  <= IRQ_DEFAULT;
      mask_q  <= '1;                // All channels enabled.
    end else begin
      rdata_q <= rd_data;
      error_q <= error_rd;          // Single cycle pulse.
      mode_q  <= mode_d;
      mask_q  <= mask_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/pkt_rx_fsm.sv */
/*
 * Packet receive FSM.
 * Steers flits of one packet at a time into its channel buffer.
 */
`timescale 1ns/100ps
`default_nettype none

module pkt_rx_fsm (
  input  wire                                         clk_axi,
  input  wire                                         arst_axi,
  input  ni_pkg::flit_t                               flit_i,
  input  wire  [ni_pkg::NumVirtChn-1:0]               full_i,
  output logic [ni_pkg::NumVirtChn-1:0]               wr_o,
  output ni_pkg::flit_data_t                          wdata_o,
  // Flit counter control.
  output logic                                        cnt_load_o,
  output ni_pkg::pkt_size_t                           cnt_val_o,
  output logic                                        cnt_dec_o,
  input  wire                                         cnt_last_i,
  // Last complete packet length per channel.
  output ni_pkg::pkt_size_t [ni_pkg::NumVirtChn-1:0]  pkt_size_o
);

  import ni_pkg::*;

  typedef enum logic {
    IDLE = 1'b0,
    BODY = 1'b1
  } rx_state_e;

  rx_state_e             state_q, state_d;
  logic [NumVirtChn-1:0] hd_sel;                 // Head channel, one-hot.
  logic [NumVirtChn-1:0] cur_sel_q;              // Active channel, one-hot.
  pkt_size_t             cur_size_q, head_size;
  logic [NumVirtChn-1:0] size_we;
  pkt_size_t             size_val;
  logic                  head_ok, body_ok, latch_hd;

  // Out of range vc ids decode to no channel, so they are dropped.
  always_comb begin
    for (int i = 0; i < NumVirtChn; i++) begin
      hd_sel[i] = (flit_i.vc == vc_id_t'(i));
    end
  end

  assign head_size = flit_i.data[7:0];
  assign head_ok   = |(hd_sel & ~full_i);        // Room on target VC.
  assign body_ok   = |(cur_sel_q & ~full_i);
  assign wdata_o   = flit_i.data;
  assign cnt_val_o = head_size - pkt_size_t'(1); // Body flits only.

  // ******************************************************************
  // Next state and strobes.
  // ******************************************************************
  always_comb begin
    state_d    = state_q;
    wr_o       = '0;
    cnt_load_o = 1'b0;
    cnt_dec_o  = 1'b0;
    size_we    = '0;
    size_val   = cur_size_q;
    latch_hd   = 1'b0;
    case (state_q)
      IDLE: begin
        // Non-head flits here belong to a dropped packet.
        if (flit_i.valid && flit_i.head && head_ok) begin
          wr_o = hd_sel;
          if (head_size <= pkt_size_t'(1)) begin
            size_we  = hd_sel;                   // Single flit packet.
            size_val = head_size;
          end else begin
            cnt_load_o = 1'b1;
            latch_hd   = 1'b1;
            state_d    = BODY;
          end
        end
      end
      BODY: begin
        if (flit_i.valid && !flit_i.head && body_ok) begin
          wr_o      = cur_sel_q;
          cnt_dec_o = 1'b1;
          if (cnt_last_i) begin
            size_we = cur_sel_q;                 // Tail written.
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      state_q    <= IDLE;
      cur_sel_q  <= '0;
      pkt_size_o <= '0;
    end else begin
      state_q <= state_d;
      if (latch_hd) begin
        cur_sel_q <= hd_sel;
      end
      for (int i = 0; i < NumVirtChn; i++) begin
        if (size_we[i]) begin
          pkt_size_o[i] <= size_val;
        end
      end
    end
  end

  // Packet length of the active packet.
  always_ff @(posedge clk_axi) begin
    if (latch_hd) begin
      cur_size_q <= head_size;
    end
  end

endmodule

`default_nettype wire

/* hdl/vc_rd_buffer.sv */
/*
 * Per virtual channel read buffer.
 * First-word-fall-through flit FIFO with status outputs.
 */
`timescale 1ns/100ps
`default_nettype none

module vc_rd_buffer #(
  parameter int unsigned FIFO_DEPTH = 4        // Power of two.
) (
  input  wire                clk_axi,
  input  wire                arst_axi,
  input  wire                wr_i,
  input  ni_pkg::flit_data_t wdata_i,
  input  wire                pop_i,
  output ni_pkg::flit_data_t rdata_o,
  output ni_pkg::vc_stat_t   stat_o
);

  import ni_pkg::*;

  localparam int unsigned PtrW = $clog2(FIFO_DEPTH);
  localparam int unsigned CntW = PtrW + 1;

  flit_data_t      mem [FIFO_DEPTH];            // Storage.
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            empty, full;
  logic            do_wr, do_pop;

  assign empty  = (cnt_q == '0);
  assign full   = (cnt_q == CntW'(FIFO_DEPTH));
  assign do_wr  = wr_i  && !full;                // Drop when full.
  assign do_pop = pop_i && !empty;               // Ignore on empty.

  assign rdata_o      = mem[rd_ptr_q];           // Head of queue.
  assign stat_o.empty = empty;
  assign stat_o.full  = full;
  assign stat_o.occup = occup_t'(cnt_q);

  // Pointers and fill count.
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + PtrW'(1);         // Wraps at depth.
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PtrW'(1);
      end
      case ({do_wr, do_pop})
        2'b10:   cnt_q <= cnt_q + CntW'(1);
        2'b01:   cnt_q <= cnt_q - CntW'(1);
        default: cnt_q <= cnt_q;                 // Idle or both.
      endcase
    end
  end

  // Data array.
  always_ff @(posedge clk_axi) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/flit_counter.sv */
/*
 * Remaining body flit counter for the packet in flight.
 */
`timescale 1ns/100ps
`default_nettype none

module flit_counter (
  input  wire               clk_axi,
  input  wire               arst_axi,
  input  wire               load_i,
  input  ni_pkg::pkt_size_t load_val_i,   // Body flit count.
  input  wire               dec_i,        // Body flit accepted.
  output logic              last_o
);

  import ni_pkg::*;

  pkt_size_t cnt_q;

  assign last_o = (cnt_q == pkt_size_t'(1)); // One body flit left.

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= load_val_i;                // Load wins.
    end else if (dec_i && cnt_q != '0) begin
      cnt_q <= cnt_q - pkt_size_t'(1);
    end
  end

endmodule

`default_nettype wire

/* hdl/ni_pkg.sv */
/*
 * NoC network interface receive package.
 * Shared widths, CSR map, interrupt modes and bus structs.
 */
`default_nettype none

package ni_pkg;

  // ******************************************************************
  // Basic widths.
  // ******************************************************************
  localparam int unsigned NumVirtChn = 3;     // Virtual channels per node.

  typedef logic [31:0] flit_data_t;           // Flit payload.
  typedef logic [7:0]  pkt_size_t;            // Packet length, head included.
  typedef logic [1:0]  vc_id_t;               // Channel index.
  typedef logic [15:0] occup_t;               // Buffer fill level.
  typedef logic [3:0]  coord_t;               // Router X/Y position.
  typedef logic [15:0] csr_addr_t;            // CSR byte address.

  // ******************************************************************
  // CSR map, byte offsets from the window base.
  // ******************************************************************
  localparam csr_addr_t CsrBaseAddr = 16'h1000;

  localparam csr_addr_t NiVersion   = 16'h0000; // RO.
  localparam csr_addr_t RouterX     = 16'h0004; // RO.
  localparam csr_addr_t RouterY     = 16'h0008; // RO.
  localparam csr_addr_t IrqStatus   = 16'h000C; // RO, live irq lines.
  localparam csr_addr_t IrqMux      = 16'h0010; // RW, irq mode.
  localparam csr_addr_t IrqMask     = 16'h0014; // RW, irq mask.
  localparam csr_addr_t TxFull      = 16'h0018; // RO, tx side level.
  localparam csr_addr_t PktSizeBase = 16'h0020; // RO, one word per VC.

  localparam logic [31:0] NiVersionLabel = 32'h4E49_0100; // "NI" v1.0.

  // Interrupt source select.
  typedef enum logic [1:0] {
    IRQ_DEFAULT = 2'd0,  // Not empty.
    IRQ_EMPTY   = 2'd1,  // Not empty, masked.
    IRQ_FULL    = 2'd2,  // Full, masked.
    IRQ_COMP    = 2'd3   // Occupancy threshold.
  } irq_mode_e;

  // ******************************************************************
  // Structs.
  // ******************************************************************
  // Simplified CSR request, one cycle strobe.
  typedef struct packed {
    logic        valid;
    logic        write;   // 1 means write.
    csr_addr_t   addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } csr_resp_t;

  typedef struct packed {
    logic [NumVirtChn-1:0] vcs;   // One line per channel.
    logic                  trig;  // Any line.
  } irq_t;

  // Incoming flit; head carries the length in data[7:0].
  typedef struct packed {
    logic       valid;
    logic       head;
    vc_id_t     vc;
    flit_data_t data;
  } flit_t;

  // Per channel buffer status.
  typedef struct packed {
    logic   empty;
    logic   full;
    occup_t occup;
  } vc_stat_t;

endpackage

`default_nettype wire
